/* lstm_cell.f */
+incdir+logic
logic/lstm_pkg.sv
logic/weight_bank_mem.sv
logic/tile_sequencer.sv
logic/mac_lanes.sv
logic/gate_activation.sv
logic/cell_state_update.sv
logic/lstm_cell_top.sv
dv/lstm_ref_model.sv
dv/lstm_cell_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lstm_cell_tb
FLIST     ?= lstm_cell.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/lstm_cell_tb.sv */
`include "lstm_consts.svh"

module lstm_cell_tb import lstm_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N          = `LSTM_IN_LEN;
    localparam int H          = `LSTM_HIDDEN;
    localparam int W_WORDS    = `LSTM_GATE_ROWS * `LSTM_IN_LEN;
    localparam int CLK_PERIOD = 100;
    localparam int RUNS       = 8;
    // Operand load, start, MVM, drain, update, busy probe and tail
    localparam int RUN_CYCLES = W_WORDS + 4 + H * N + 3 + H + 10 + N + 10;

    logic                       clk;
    logic                       rst_n;
    logic                       weight_we;
    logic [`LSTM_W_ADDR_W-1:0]  weight_addr;
    word_t                      weight_in;
    logic                       x_we;
    logic [`LSTM_X_ADDR_W-1:0]  x_addr;
    word_t                      x_in;
    logic                       start;
    word_t                      ht_output;
    logic                       ht_valid;
    logic                       busy;
    logic                       done;

    word_t w_buf [W_WORDS];
    word_t x_buf [N];
    word_t saved_w [W_WORDS];
    word_t saved_x [N];
    word_t saved_h [H];
    word_t exp_h [H];
    int    hv_count;
    int    done_count;

    lstm_cell_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_we   (weight_we),
        .weight_addr (weight_addr),
        .weight_in   (weight_in),
        .x_we        (x_we),
        .x_addr      (x_addr),
        .x_in        (x_in),
        .start       (start),
        .ht_output   (ht_output),
        .ht_valid    (ht_valid),
        .busy        (busy),
        .done        (done)
    );

    lstm_ref_model ref_model ();

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(2 * RUNS * (RUN_CYCLES + 8) * CLK_PERIOD);
        $display("Timeout at %0t, the DUT did not finish its runs", $time);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    task automatic check_hidden(input int idx, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: ht_output[%0d] got %0d expected %0d",
                     $time, idx, got, exp);
            $display("Errors found");
            $fatal(1, "hidden value check failed");
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "count check failed");
        end
    endtask

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (ht_valid) begin
                if (hv_count < H) begin
                    check_hidden(hv_count, ht_output, exp_h[hv_count]);
                end else begin
                    check_count("ht_valid pulses", hv_count + 1, H);
                end
                hv_count++;
            end
            if (done) begin
                check_count("ht_valid with done", int'(ht_valid), 1);
                check_count("ht_valid before done", hv_count, H);
                done_count++;
            end
        end
    end

    function automatic word_t random_word(input bit full_range);
        if (full_range) begin
            return word_t'($urandom);
        end
        // Range of plus or minus 2.0
        return word_t'(int'($urandom_range(1024, 0)) - 512);
    endfunction

    task automatic fill_weights(input bit full_range);
        for (int a = 0; a < W_WORDS; a++) begin
            w_buf[a] = random_word(full_range);
        end
    endtask

    task automatic fill_inputs(input bit full_range);
        for (int j = 0; j < N; j++) begin
            x_buf[j] = random_word(full_range);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        ref_model.clear_state();
    endtask

    // Input vector goes in alongside the first weight words
    task automatic write_operands();
        for (int a = 0; a < W_WORDS; a++) begin
            @(posedge clk);
            weight_we   <= 1'b1;
            weight_addr <= `LSTM_W_ADDR_W'(a);
            weight_in   <= w_buf[a];
            x_we        <= (a < N);
            x_addr      <= `LSTM_X_ADDR_W'(a % N);
            x_in        <= x_buf[a % N];
            ref_model.set_weight(a, int'(w_buf[a]));
        end
        for (int j = 0; j < N; j++) begin
            ref_model.set_input(j, int'(x_buf[j]));
        end
        @(posedge clk);
        weight_we <= 1'b0;
        x_we      <= 1'b0;
    endtask

    task automatic run_once(input bit poke_busy, input bit use_saved);
        write_operands();
        ref_model.compute_step();
        for (int k = 0; k < H; k++) begin
            exp_h[k] = use_saved ? saved_h[k] : word_t'(ref_model.expected_hidden(k));
        end
        hv_count   = 0;
        done_count = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // Busy is up one edge after the start pulse
        @(negedge clk);
        check_count("busy after start", int'(busy), 1);
        if (poke_busy) begin
            // A start in the middle of the MVM phase must be ignored
            repeat (N + 2) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        while (done_count == 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_count("ht_valid pulses", hv_count, H);
        check_count("done pulses", done_count, 1);
        check_count("busy", int'(busy), 0);
    endtask

    initial begin
        void'($urandom(32'he288));
        rst_n       = 1'b0;
        weight_we   = 1'b0;
        weight_addr = '0;
        weight_in   = '0;
        x_we        = 1'b0;
        x_addr      = '0;
        x_in        = '0;
        start       = 1'b0;
        hv_count    = 0;
        done_count  = 0;
        apply_reset();

        // First run from a cleared cell state
        fill_weights(1'b0);
        fill_inputs(1'b0);
        saved_w = w_buf;
        saved_x = x_buf;
        run_once(1'b1, 1'b0);
        saved_h = exp_h;

        // Sequence with the cell state carried over
        repeat (5) begin
            fill_inputs(1'b0);
            run_once(1'b0, 1'b0);
        end

        // Full range operands drive saturation and clamping
        fill_weights(1'b1);
        fill_inputs(1'b1);
        run_once(1'b0, 1'b0);

        // Reset clears the cell state, first run must repeat
        apply_reset();
        w_buf = saved_w;
        x_buf = saved_x;
        run_once(1'b1, 1'b1);

        $display("No errors");
        $finish;
    end

endmodule

/* dv/lstm_ref_model.sv */
`include "lstm_consts.svh"

module lstm_ref_model;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N    = `LSTM_IN_LEN;
    localparam int H    = `LSTM_HIDDEN;
    localparam int ROWS = `LSTM_GATE_ROWS;

    int w_rows [ROWS][N];
    int x_vec [N];
    int c_state [H];
    int h_vals [H];

    // Q8.8 product rounded toward minus infinity
    function automatic int fx_mul(int a, int b);
        longint p;
        p = longint'(a) * longint'(b);
        return int'(p >>> `LSTM_FRAC_BITS);
    endfunction

    function automatic int clamp(int v, int lo, int hi);
        if (v < lo) begin
            return lo;
        end
        if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    function automatic int sat16(int v);
        return clamp(v, -32768, 32767);
    endfunction

    function automatic int sigmoid_approx(int v);
        return clamp((v >>> 2) + 128, 0, 256);
    endfunction

    function automatic int tanh_approx(int v);
        return clamp(v, -256, 256);
    endfunction

    function automatic void set_weight(int addr, int val);
        w_rows[addr / N][addr % N] = val;
    endfunction

    function automatic void set_input(int idx, int val);
        x_vec[idx] = val;
    endfunction

    function automatic void clear_state();
        for (int k = 0; k < H; k++) begin
            c_state[k] = 0;
        end
    endfunction

    // One LSTM step, updates the carried cell state
    function automatic void compute_step();
        int pre [ROWS];
        int acc;
        int f;
        int i;
        int g;
        int o;
        for (int r = 0; r < ROWS; r++) begin
            acc = 0;
            for (int j = 0; j < N; j++) begin
                acc += fx_mul(w_rows[r][j], x_vec[j]);
            end
            pre[r] = sat16(acc);
        end
        for (int k = 0; k < H; k++) begin
            f = sigmoid_approx(pre[k]);
            i = sigmoid_approx(pre[H + k]);
            g = tanh_approx(pre[2 * H + k]);
            o = sigmoid_approx(pre[3 * H + k]);
            c_state[k] = sat16(fx_mul(f, c_state[k]) + fx_mul(i, g));
            h_vals[k]  = sat16(fx_mul(o, tanh_approx(c_state[k])));
        end
    endfunction

    function automatic int expected_hidden(int idx);
        return h_vals[idx];
    endfunction

endmodule

/* logic/lstm_cell_top.sv */
`include "lstm_consts.svh"

module lstm_cell_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              weight_we,
    input  logic [`LSTM_W_ADDR_W-1:0]         weight_addr,
    input  logic signed [`LSTM_WORD_W-1:0]    weight_in,
    input  logic                              x_we,
    input  logic [`LSTM_X_ADDR_W-1:0]         x_addr,
    input  logic signed [`LSTM_WORD_W-1:0]    x_in,
    input  logic                              start,
    output logic signed [`LSTM_WORD_W-1:0]    ht_output,
    output logic                              ht_valid,
    output logic                              busy,
    output logic                              done
);

    logic [`LSTM_BANK_ADDR_W-1:0]               w_rd_addr;
    logic [`LSTM_X_ADDR_W-1:0]                  x_rd_addr;
    logic [`LSTM_LANES-1:0][`LSTM_WORD_W-1:0]   w_lane;
    logic [`LSTM_WORD_W-1:0]                    x_word;
    logic                                       mac_en;
    logic                                       mac_first;
    logic [`LSTM_LANES-1:0][`LSTM_WORD_W-1:0]   lane_sum;
    logic                                       sums_valid;
    logic                                       upd_en;
    logic [`LSTM_H_IDX_W-1:0]                   upd_idx;
    logic                                       upd_last;
    logic [`LSTM_WORD_W-1:0]                    f_val;
    logic [`LSTM_WORD_W-1:0]                    i_val;
    logic [`LSTM_WORD_W-1:0]                    g_val;
    logic [`LSTM_WORD_W-1:0]                    o_val;

    weight_bank_mem u_mem (
        .clk         (clk),
        .weight_we   (weight_we),
        .weight_addr (weight_addr),
        .weight_in   (weight_in),
        .x_we        (x_we),
        .x_addr      (x_addr),
        .x_in        (x_in),
        .w_rd_addr   (w_rd_addr),
        .x_rd_addr   (x_rd_addr),
        .w_lane      (w_lane),
        .x_word      (x_word)
    );

    tile_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .done      (done),
        .w_rd_addr (w_rd_addr),
        .x_rd_addr (x_rd_addr),
        .mac_en    (mac_en),
        .mac_first (mac_first),
        .upd_en    (upd_en),
        .upd_idx   (upd_idx),
        .upd_last  (upd_last),
        .busy      (busy)
    );

    mac_lanes u_mac (
        .clk        (clk),
        .rst_n      (rst_n),
        .mac_en     (mac_en),
        .mac_first  (mac_first),
        .w_lane     (w_lane),
        .x_word     (x_word),
        .lane_sum   (lane_sum),
        .sums_valid (sums_valid)
    );

    gate_activation u_act (
        .clk        (clk),
        .rst_n      (rst_n),
        .sums_valid (sums_valid),
        .lane_sum   (lane_sum),
        .upd_idx    (upd_idx),
        .f_val      (f_val),
        .i_val      (i_val),
        .g_val      (g_val),
        .o_val      (o_val)
    );

    cell_state_update u_cell (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd_en    (upd_en),
        .upd_idx   (upd_idx),
        .upd_last  (upd_last),
        .f_val     (f_val),
        .i_val     (i_val),
        .g_val     (g_val),
        .o_val     (o_val),
        .ht_output (ht_output),
        .ht_valid  (ht_valid),
        .done      (done)
    );

endmodule

/* logic/cell_state_update.sv */
`include "lstm_consts.svh"

module cell_state_update import lstm_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        upd_en,
    input  logic [`LSTM_H_IDX_W-1:0]    upd_idx,
    input  logic                        upd_last,
    input  word_t                       f_val,
    input  word_t                       i_val,
    input  word_t                       g_val,
    input  word_t                       o_val,
    output word_t                       ht_output,
    output logic                        ht_valid,
    output logic                        done
);

    // Cell state carried from run to run
    word_t c_mem [`LSTM_HIDDEN];

    acc_t  c_sum;
    word_t c_next;

    logic  s1_valid;
    logic  s1_last;
    word_t s1_c;
    word_t s1_o;

    // c = f*c_prev + i*g
    always_comb begin
        c_sum  = q_mul(f_val, c_mem[upd_idx]) + q_mul(i_val, g_val);
        c_next = sat_word(c_sum);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `LSTM_HIDDEN; k++) begin
                c_mem[k] <= '0;
            end
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            ht_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (upd_en) begin
                c_mem[upd_idx] <= c_next;
            end
            s1_valid <= upd_en;
            s1_last  <= upd_en && upd_last;
            ht_valid <= s1_valid;
            done     <= s1_valid && s1_last;
        end
    end

    // Stage two, h = o * tanh(c)
    always_ff @(posedge clk) begin
        if (upd_en) begin
            s1_c <= c_next;
            s1_o <= o_val;
        end
        if (s1_valid) begin
            ht_output <= sat_word(q_mul(s1_o, hard_tanh(s1_c)));
        end
    end

endmodule

/* logic/gate_activation.sv */
`include "lstm_consts.svh"

module gate_activation import lstm_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sums_valid,
    input  word_t [`LSTM_LANES-1:0]     lane_sum,
    input  logic [`LSTM_H_IDX_W-1:0]    upd_idx,
    output word_t                       f_val,
    output word_t                       i_val,
    output word_t                       g_val,
    output word_t                       o_val
);

    localparam int PTR_W = $clog2(`LSTM_GATE_ROWS);
    localparam int H_W   = `LSTM_H_IDX_W;
    localparam int GATES = 4;

    word_t gate_buf [GATES][`LSTM_HIDDEN];

    // Row of the next group, wraps once per run
    logic [PTR_W-1:0] wr_ptr;

    logic [PTR_W-1:0] slot_row [`LSTM_LANES];
    logic [H_W-1:0]   slot_elem [`LSTM_LANES];
    gate_t            slot_gate [`LSTM_LANES];
    word_t            slot_act [`LSTM_LANES];

    always_comb begin
        for (int k = 0; k < `LSTM_LANES; k++) begin
            slot_row[k]  = wr_ptr + PTR_W'(k);
            slot_gate[k] = gate_t'(slot_row[k] / `LSTM_HIDDEN);
            slot_elem[k] = H_W'(slot_row[k] % `LSTM_HIDDEN);
            // Candidate gate uses tanh, the rest sigmoid
            if (slot_gate[k] == GATE_G) begin
                slot_act[k] = hard_tanh(lane_sum[k]);
            end else begin
                slot_act[k] = hard_sigmoid(lane_sum[k]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (sums_valid) begin
            wr_ptr <= wr_ptr + PTR_W'(`LSTM_LANES);
        end
    end

    always_ff @(posedge clk) begin
        if (sums_valid) begin
            for (int k = 0; k < `LSTM_LANES; k++) begin
                gate_buf[slot_gate[k]][slot_elem[k]] <= slot_act[k];
            end
        end
    end

    assign f_val = gate_buf[GATE_F][upd_idx];
    assign i_val = gate_buf[GATE_I][upd_idx];
    assign g_val = gate_buf[GATE_G][upd_idx];
    assign o_val = gate_buf[GATE_O][upd_idx];

endmodule

/* logic/mac_lanes.sv */
`include "lstm_consts.svh"

module mac_lanes import lstm_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        mac_en,
    input  logic                        mac_first,
    input  word_t [`LSTM_LANES-1:0]     w_lane,
    input  word_t                       x_word,
    output word_t [`LSTM_LANES-1:0]     lane_sum,
    output logic                        sums_valid
);

    acc_t acc [`LSTM_LANES];

    logic [`LSTM_X_ADDR_W-1:0] col_cnt;
    logic [`LSTM_X_ADDR_W-1:0] col_idx;

    // Column of the current beat
    assign col_idx = mac_first ? '0 : col_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt    <= '0;
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= mac_en && (col_idx == `LSTM_IN_LEN - 1);
            if (mac_en) begin
                col_cnt <= col_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mac_en) begin
            for (int k = 0; k < `LSTM_LANES; k++) begin
                acc[k] <= (mac_first ? acc_t'(0) : acc[k]) + q_mul(w_lane[k], x_word);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `LSTM_LANES; k++) begin
            lane_sum[k] = sat_word(acc[k]);
        end
    end

endmodule

/* logic/tile_sequencer.sv */
`include "lstm_consts.svh"

module tile_sequencer import lstm_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            done,
    output logic [`LSTM_BANK_ADDR_W-1:0]    w_rd_addr,
    output logic [`LSTM_X_ADDR_W-1:0]       x_rd_addr,
    output logic                            mac_en,
    output logic                            mac_first,
    output logic                            upd_en,
    output logic [`LSTM_H_IDX_W-1:0]        upd_idx,
    output logic                            upd_last,
    output logic                            busy
);

    localparam int GROUPS       = `LSTM_GATE_ROWS / `LSTM_LANES;
    localparam int GRP_W        = $clog2(GROUPS);
    localparam int BANK_AW      = `LSTM_BANK_ADDR_W;
    localparam int DRAIN_CYCLES = 3;

    ctrl_state_t state;

    logic [GRP_W-1:0]          grp;
    logic [`LSTM_X_ADDR_W-1:0] col;
    logic [1:0]                drain_cnt;
    logic                      col_last;
    logic                      grp_last;

    assign col_last = (col == `LSTM_IN_LEN - 1);
    assign grp_last = (grp == GROUPS - 1);

    // Group g reads local row g of every bank
    assign w_rd_addr = BANK_AW'(grp * `LSTM_IN_LEN + col);
    assign x_rd_addr = col;

    assign busy     = (state != CTRL_IDLE);
    assign upd_en   = (state == CTRL_UPDATE);
    assign upd_last = upd_en && (upd_idx == `LSTM_HIDDEN - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CTRL_IDLE;
            grp       <= '0;
            col       <= '0;
            drain_cnt <= '0;
            upd_idx   <= '0;
            mac_en    <= 1'b0;
            mac_first <= 1'b0;
        end else begin
            // Strobes trail the read address by the memory latency
            mac_en    <= (state == CTRL_MVM);
            mac_first <= (state == CTRL_MVM) && (col == '0);

            case (state)
                CTRL_IDLE: begin
                    if (start) begin
                        state <= CTRL_MVM;
                        grp   <= '0;
                        col   <= '0;
                    end
                end
                CTRL_MVM: begin
                    if (col_last) begin
                        col <= '0;
                        grp <= grp + 1'b1;
                        if (grp_last) begin
                            state     <= CTRL_DRAIN;
                            drain_cnt <= '0;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                CTRL_DRAIN: begin
                    // Covers the MAC and activation pipeline
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_CYCLES - 1) begin
                        state   <= CTRL_UPDATE;
                        upd_idx <= '0;
                    end
                end
                CTRL_UPDATE: begin
                    upd_idx <= upd_idx + 1'b1;
                    if (upd_last) begin
                        state <= CTRL_WAIT;
                    end
                end
                CTRL_WAIT: begin
                    // Last hidden value still in the update pipeline
                    if (done) begin
                        state <= CTRL_IDLE;
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/weight_bank_mem.sv */
`include "lstm_consts.svh"

module weight_bank_mem import lstm_pkg::*; (
    input  logic                            clk,
    input  logic                            weight_we,
    input  logic [`LSTM_W_ADDR_W-1:0]       weight_addr,
    input  word_t                           weight_in,
    input  logic                            x_we,
    input  logic [`LSTM_X_ADDR_W-1:0]       x_addr,
    input  word_t                           x_in,
    input  logic [`LSTM_BANK_ADDR_W-1:0]    w_rd_addr,
    input  logic [`LSTM_X_ADDR_W-1:0]       x_rd_addr,
    output word_t [`LSTM_LANES-1:0]         w_lane,
    output word_t                           x_word
);

    localparam int WA         = `LSTM_W_ADDR_W;
    localparam int BANK_AW    = `LSTM_BANK_ADDR_W;
    localparam int LANE_W     = $clog2(`LSTM_LANES);
    localparam int BANK_DEPTH = `LSTM_GATE_ROWS / `LSTM_LANES * `LSTM_IN_LEN;

    word_t bank_mem [`LSTM_LANES][BANK_DEPTH];
    word_t x_mem [`LSTM_IN_LEN];

    logic [WA-1:0]      wr_row;
    logic [LANE_W-1:0]  wr_bank;
    logic [BANK_AW-1:0] wr_local;

    // Rows are interleaved over the banks, row r lives in bank r mod 4
    assign wr_row   = WA'(weight_addr / `LSTM_IN_LEN);
    assign wr_bank  = LANE_W'(wr_row % `LSTM_LANES);
    assign wr_local = BANK_AW'((wr_row / `LSTM_LANES) * `LSTM_IN_LEN
                               + weight_addr % `LSTM_IN_LEN);

    always_ff @(posedge clk) begin
        if (weight_we) begin
            bank_mem[wr_bank][wr_local] <= weight_in;
        end
        if (x_we) begin
            x_mem[x_addr] <= x_in;
        end
        // All banks read at the same local address
        for (int k = 0; k < `LSTM_LANES; k++) begin
            w_lane[k] <= bank_mem[k][w_rd_addr];
        end
        x_word <= x_mem[x_rd_addr];
    end

endmodule

/* logic/lstm_pkg.sv */
`include "lstm_consts.svh"

package lstm_pkg;

    typedef logic signed [`LSTM_WORD_W-1:0] word_t;
    typedef logic signed [2*`LSTM_WORD_W-1:0] acc_t;

    // Numeric order matches the row blocks of the weight matrix
    typedef enum logic [1:0] {
        GATE_F = 2'd0,
        GATE_I = 2'd1,
        GATE_G = 2'd2,
        GATE_O = 2'd3
    } gate_t;

    typedef enum logic [2:0] {
        CTRL_IDLE   = 3'd0,
        CTRL_MVM    = 3'd1,
        CTRL_DRAIN  = 3'd2,
        CTRL_UPDATE = 3'd3,
        CTRL_WAIT   = 3'd4
    } ctrl_state_t;

    // Q8.8 product, floor of the full product
    function automatic acc_t q_mul(word_t a, word_t b);
        acc_t p;
        p = acc_t'(a) * acc_t'(b);
        return p >>> `LSTM_FRAC_BITS;
    endfunction

    function automatic word_t sat_word(acc_t v);
        acc_t hi;
        acc_t lo;
        hi = (acc_t'(1) <<< (`LSTM_WORD_W - 1)) - 1;
        lo = -hi - 1;
        if (v > hi) begin
            return word_t'(hi);
        end
        if (v < lo) begin
            return word_t'(lo);
        end
        return word_t'(v);
    endfunction

    // 0.5 + x/4, limited to [0, 1]
    function automatic word_t hard_sigmoid(word_t x);
        acc_t t;
        t = acc_t'(x >>> 2) + (`LSTM_ONE / 2);
        if (t < 0) begin
            return '0;
        end
        if (t > `LSTM_ONE) begin
            return word_t'(`LSTM_ONE);
        end
        return word_t'(t);
    endfunction

    function automatic word_t hard_tanh(word_t x);
        if (x > `LSTM_ONE) begin
            return word_t'(`LSTM_ONE);
        end
        if (x < -`LSTM_ONE) begin
            return word_t'(-`LSTM_ONE);
        end
        return x;
    endfunction

endpackage

/* logic/lstm_consts.svh */
`ifndef LSTM_CONSTS_SVH
`define LSTM_CONSTS_SVH

// Q8.8 fixed point format
`define LSTM_FRAC_BITS 8
`define LSTM_WORD_W 16

// Input vector length N and hidden size H
`define LSTM_IN_LEN 8
`define LSTM_HIDDEN 8

// One MAC lane per weight bank
`define LSTM_LANES 4
`define LSTM_GATE_ROWS (4 * `LSTM_HIDDEN)

// Address widths
`define LSTM_W_ADDR_W 8
`define LSTM_BANK_ADDR_W 6
`define LSTM_X_ADDR_W 3
`define LSTM_H_IDX_W 3

// 1.0 in Q8.8
`define LSTM_ONE (1 << `LSTM_FRAC_BITS)

`endif
